//--- program.hex
// One 32-bit instruction word per line in hex, word 0 sits at byte address 0
// Fields: opcode [31:25], rd or rs1 [24:22], rs1 or rs2 [21:19], rs2 [18:16], imm16 [15:0]
04400005 // 00 ADDI r1, r0, 5
0480FFFD // 04 ADDI r2, r0, -3
02CA0000 // 08 ADD  r3, r1, r2
050003E8 // 0C ADDI r4, r0, 1000
05407ABC // 10 ADDI r5, r0, 0x7ABC
09AD0000 // 14 MUL  r6, r5, r5
03F10000 // 18 ADD  r7, r6, r1
82500008 // 1C BEQ  r1, r2, +8 (not taken)
0448FFFF // 20 ADDI r1, r1, -1
82000008 // 24 BEQ  r0, r0, +8 (taken)
05C00BAD // 28 ADDI r7, r0, 0x0BAD (skipped)
C000000C // 2C B    +12
04D80007 // 30 ADDI r3, r3, 7
C0000010 // 34 B    +16
C8000000 // 38 NOP
0520FC18 // 3C ADDI r4, r4, -1000
C000FFF0 // 40 B    -16
0480000C // 44 ADDI r2, r0, 12
84800000 // 48 BR   r2
05C0DEAD // 4C ADDI r7, r0, 0xDEAD (skipped)
05C00BAD // 50 ADDI r7, r0, 0x0BAD (skipped)
095A0000 // 54 MUL  r5, r3, r2
03AB0000 // 58 ADD  r6, r5, r3
C0000000 // 5C B    0 (end of program)

//--- filelist.f
+incdir+.
isaPkg.sv
fetchPkg.sv
redirectIf.sv
instrRom.sv
iFetch.sv
execUnit.sv
mulUnit.sv
cpuCore.sv
tbCpuCore.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbCpuCore
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- tbRefModel.svh
// ==============================
// Instruction-level reference model that builds the expected retire list
// ==============================
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Opcode values of the instruction set
localparam logic [6:0] opAdd    = 7'b0000001;
localparam logic [6:0] opAddi   = 7'b0000010;
localparam logic [6:0] opMul    = 7'b0000100;
localparam logic [6:0] opBeq    = 7'b1000001;
localparam logic [6:0] opBr     = 7'b1000010;
localparam logic [6:0] opB      = 7'b1100000;
localparam int         maxSteps = 1000;
localparam int         romAddrWidth = $clog2(romDepth);

logic [31:0] refRom [romDepth];
logic [2:0]  expReg [$];
logic [31:0] expData [$];
// All ones until the model finds the self-branch
logic [31:0] endPc = '1;

// Program word at a byte address, zero past the image
function automatic isaPkg::instrWord_u wordAt(input logic [31:0] pc);
    isaPkg::instrWord_u word;
    word = '0;
    if ((pc >> 2) < romDepth) begin
        word = refRom[pc[romAddrWidth+1:2]];
    end
    return word;
endfunction

function automatic logic [31:0] signExtend16(input logic [15:0] value);
    return {{16{value[15]}}, value};
endfunction

function automatic void recordRetire(input logic [2:0] rd, input logic [31:0] value);
    expReg.push_back(rd);
    expData.push_back(value);
endfunction

// Runs the program up to its self-branch, returns the cycle count
function automatic int buildExpected();
    logic [31:0]        regs [8];
    logic [31:0]        pc;
    logic [31:0]        pcNext;
    logic [63:0]        opMask;
    logic [63:0]        prod;
    logic [6:0]         opcode;
    isaPkg::instrWord_u word;
    int                 cycles;
    int                 steps;
    $readmemh("program.hex", refRom);
    for (int i = 0; i < 8; i++) begin
        regs[i] = '0;
    end
    opMask = (64'd1 << mulWidth) - 64'd1;
    pc     = 32'h0;
    cycles = 0;
    steps  = 0;
    while (endPc == '1 && steps < maxSteps) begin
        word   = wordAt(pc);
        opcode = word.aluView.opcode;
        pcNext = pc + 32'd4;
        cycles = cycles + 1;
        steps  = steps + 1;
        case (opcode)
            opAdd: begin
                regs[word.aluView.rd] = regs[word.aluView.rs1] + regs[word.aluView.rs2];
                recordRetire(word.aluView.rd, regs[word.aluView.rd]);
            end
            opAddi: begin
                regs[word.aluView.rd] = regs[word.aluView.rs1]
                                      + signExtend16(word.aluView.imm16);
                recordRetire(word.aluView.rd, regs[word.aluView.rd]);
            end
            opMul: begin
                prod = (64'(regs[word.aluView.rs1]) & opMask)
                     * (64'(regs[word.aluView.rs2]) & opMask);
                regs[word.aluView.rd] = prod[31:0];
                recordRetire(word.aluView.rd, regs[word.aluView.rd]);
                cycles = cycles + mulWidth;
            end
            opBeq: begin
                if (regs[word.brView.rs1] == regs[word.brView.rs2]) begin
                    pcNext = pc + signExtend16(word.brView.imm16);
                end
            end
            opBr: begin
                pcNext = pc + signExtend16(regs[word.brView.rs1][15:0]);
            end
            opB: begin
                pcNext = pc + signExtend16(word.brView.imm16);
            end
            // NOP and unknown words just step
            default: begin
            end
        endcase
        if (pcNext == pc) begin
            endPc = pc;
        end
        pc = pcNext;
    end
    return cycles;
endfunction

`endif

//--- tbCpuCore.sv
// ==============================
// Testbench for the processor core with retire checker,
// PC hold check around MUL and watchdog
// ==============================
`timescale 1ns/10ps

module tbCpuCore;

    localparam int romDepth    = 64;
    localparam int mulWidth    = 16;
    localparam int resetCycles = 5;
    localparam int quietCycles = 10;

    logic        clk;
    logic        rst;
    logic [31:0] programCounter;
    logic        retireValid;
    logic [2:0]  retireReg;
    logic [31:0] retireData;

    int          valueErrors = 0;
    int          otherErrors = 0;
    int          retireIdx = 0;
    int          postResetCycles = 0;
    int          modelCycles;
    logic        modelReady;
    logic        endReached = 1'b0;
    logic [31:0] prevPc = '0;
    // MUL hold tracking
    logic        inMulHold = 1'b0;
    logic        awaitStep = 1'b0;
    logic        inAddCheck = 1'b0;
    logic [31:0] mulPc = '0;
    int          addRetires = 0;

    `include "tbRefModel.svh"

    cpuCore #(.romDepth(romDepth), .mulWidth(mulWidth)) u_dut (
        .clk            (clk),
        .rst            (rst),
        .programCounter (programCounter),
        .retireValid    (retireValid),
        .retireReg      (retireReg),
        .retireData     (retireData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==============================
    // Checks
    // ==============================
    task automatic verifyResetState(input string phase);
        if (retireValid !== 1'b0) begin
            $display("[FAIL] t=%0t retireValid expected 0 got %b (%s)",
                     $time, retireValid, phase);
            valueErrors++;
        end
        if (programCounter !== 32'h0) begin
            $display("[FAIL] t=%0t programCounter expected 0x%08h got 0x%08h (%s)",
                     $time, 32'h0, programCounter, phase);
            valueErrors++;
        end
    endtask

    task automatic compareRetire();
        if (retireIdx >= expReg.size()) begin
            $display("Unexpected extra retire at t=%0t to register %0d", $time, retireReg);
            otherErrors++;
        end else begin
            if (retireReg !== expReg[retireIdx]) begin
                $display("[FAIL] t=%0t retireReg expected %0d got %0d",
                         $time, expReg[retireIdx], retireReg);
                valueErrors++;
            end
            if (retireData !== expData[retireIdx]) begin
                $display("[FAIL] t=%0t retireData expected 0x%08h got 0x%08h",
                         $time, expData[retireIdx], retireData);
                valueErrors++;
            end
            retireIdx++;
        end
    endtask

    // PC frozen from MUL issue to its retire, then one step to the ADD
    task automatic trackMulHold();
        isaPkg::instrWord_u word;
        word = wordAt(programCounter);
        if (inMulHold) begin
            if (programCounter !== mulPc) begin
                $display("[FAIL] t=%0t programCounter expected 0x%08h got 0x%08h",
                         $time, mulPc, programCounter);
                valueErrors++;
                inMulHold = 1'b0;
            end else if (retireValid) begin
                inMulHold = 1'b0;
                awaitStep = 1'b1;
            end
        end else if (awaitStep) begin
            if (programCounter !== mulPc) begin
                awaitStep = 1'b0;
                if (programCounter !== mulPc + 32'd4) begin
                    $display("[FAIL] t=%0t programCounter expected 0x%08h got 0x%08h",
                             $time, mulPc + 32'd4, programCounter);
                    valueErrors++;
                end else begin
                    inAddCheck = 1'b1;
                    addRetires = 0;
                end
            end
        end else if (word.aluView.opcode == opMul && !inAddCheck) begin
            inMulHold = 1'b1;
            mulPc     = programCounter;
        end
        if (inAddCheck) begin
            if (programCounter === mulPc + 32'd4) begin
                if (retireValid) begin
                    addRetires++;
                end
            end else begin
                inAddCheck = 1'b0;
                if (addRetires != 1) begin
                    $display("Instruction after the MUL at 0x%08h retired %0d times",
                             mulPc, addRetires);
                    otherErrors++;
                end
            end
        end
    endtask

    // Sampled on the falling edge, away from the drive point
    always @(negedge clk) begin
        if (rst) begin
            verifyResetState("during reset");
        end else begin
            postResetCycles++;
            if (postResetCycles == 1) begin
                verifyResetState("first cycle after reset");
            end else begin
                if (retireValid) begin
                    compareRetire();
                end
                trackMulHold();
                if (!endReached && programCounter == endPc && prevPc == endPc) begin
                    endReached = 1'b1;
                    if (retireIdx != expReg.size()) begin
                        $display("Final self-branch reached with %0d of %0d retires seen",
                                 retireIdx, expReg.size());
                        otherErrors++;
                    end
                end
            end
        end
        prevPc = programCounter;
    end

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        rst         = 1'b1;
        modelReady  = 1'b0;
        modelCycles = buildExpected();
        modelReady  = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 rst = 1'b0;
        wait (endReached === 1'b1);
        // Nothing more may retire once the program spins
        repeat (quietCycles) @(negedge clk);
        #1;
        $display("Errors: %0d wrong values, %0d other failures, %0d of %0d retires seen",
                 valueErrors, otherErrors, retireIdx, expReg.size());
        if (valueErrors + otherErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (modelReady === 1'b1);
        wait (rst === 1'b0);
        repeat (2 * modelCycles + 20) @(posedge clk);
        $display("Timeout after %0d cycles, %0d of %0d expected retires never seen",
                 2 * modelCycles + 20, expReg.size() - retireIdx, expReg.size());
        otherErrors++;
        $display("Errors: %0d wrong values, %0d other failures, %0d of %0d retires seen",
                 valueErrors, otherErrors, retireIdx, expReg.size());
        $display("Test failed");
        $finish;
    end

endmodule

//--- cpuCore.sv
// ==============================
// Processor top level with ROM, fetch, execute and multiplier
// ==============================
`timescale 1ns/10ps

module cpuCore #(
    parameter int romDepth = 64,
    parameter int mulWidth = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    output logic [31:0]                    programCounter,
    output logic                           retireValid,
    output logic [isaPkg::regIdxWidth-1:0] retireReg,
    output logic [31:0]                    retireData
);

    isaPkg::instrWord_u    fetchedInstruction;
    isaPkg::instrWord_u    filteredInstruction;
    logic                  issueValid;
    logic                  mulStart;
    logic [mulWidth-1:0]   mulA;
    logic [mulWidth-1:0]   mulB;
    logic                  mulBusy;
    logic                  mulDone;
    logic [2*mulWidth-1:0] mulProduct;

    redirectIf redirect ();

    instrRom #(.romDepth(romDepth)) u_instrRom (
        .programCounter     (programCounter),
        .fetchedInstruction (fetchedInstruction)
    );

    // Multiplier busy doubles as the fetch hold
    iFetch u_iFetch (
        .clk                 (clk),
        .rst                 (rst),
        .fetchedInstruction  (fetchedInstruction),
        .redirect            (redirect.fetch),
        .control             (mulBusy),
        .programCounter      (programCounter),
        .filteredInstruction (filteredInstruction),
        .issueValid          (issueValid)
    );

    execUnit #(.mulWidth(mulWidth)) u_execUnit (
        .clk                 (clk),
        .rst                 (rst),
        .filteredInstruction (filteredInstruction),
        .issueValid          (issueValid),
        .redirect            (redirect.exec),
        .mulStart            (mulStart),
        .mulA                (mulA),
        .mulB                (mulB),
        .mulDone             (mulDone),
        .mulProduct          (mulProduct),
        .retireValid         (retireValid),
        .retireReg           (retireReg),
        .retireData          (retireData)
    );

    mulUnit #(.mulWidth(mulWidth)) u_mulUnit (
        .clk     (clk),
        .rst     (rst),
        .start   (mulStart),
        .a       (mulA),
        .b       (mulB),
        .busy    (mulBusy),
        .done    (mulDone),
        .product (mulProduct)
    );

endmodule

//--- mulUnit.sv
// ==============================
// Iterative shift-add multiplier
// ==============================
`timescale 1ns/10ps

module mulUnit #(
    parameter int mulWidth = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic [mulWidth-1:0]   a,
    input  logic [mulWidth-1:0]   b,
    output logic                  busy,
    output logic                  done,
    output logic [2*mulWidth-1:0] product
);

    localparam int cntWidth = $clog2(mulWidth);

    logic                  running;
    logic [cntWidth-1:0]   stepCount;
    logic [2*mulWidth-1:0] accum;
    logic [2*mulWidth-1:0] accumNext;
    logic [2*mulWidth-1:0] multiplicand;
    logic [mulWidth-1:0]   multiplier;
    logic                  lastStep;

    // One partial product per cycle, LSB of multiplier first
    assign accumNext = multiplier[0] ? (accum + multiplicand) : accum;
    assign lastStep  = running && (stepCount == cntWidth'(mulWidth - 1));

    // ==============================
    // Control
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            running   <= 1'b0;
            stepCount <= '0;
        end else if (start) begin
            running   <= 1'b1;
            stepCount <= '0;
        end else if (running) begin
            running   <= !lastStep;
            stepCount <= lastStep ? '0 : stepCount + 1'b1;
        end
    end

    // ==============================
    // Datapath
    // ==============================
    always_ff @(posedge clk) begin
        if (start) begin
            accum        <= '0;
            multiplicand <= {{mulWidth{1'b0}}, a};
            multiplier   <= b;
        end else if (running) begin
            accum        <= accumNext;
            multiplicand <= multiplicand << 1;
            multiplier   <= multiplier >> 1;
        end
    end

    // Busy spans the start cycle too, so fetch holds right away
    assign busy    = start || running;
    assign done    = lastStep;
    // Final step's sum is complete in the done cycle
    assign product = accumNext;

endmodule

//--- execUnit.sv
// ==============================
// Execute unit with register file, ALU, branch resolve,
// multiplier launch and retire reporting
// ==============================
`timescale 1ns/10ps

module execUnit #(
    parameter int mulWidth = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  isaPkg::instrWord_u             filteredInstruction,
    input  logic                           issueValid,
    redirectIf.exec                        redirect,
    output logic                           mulStart,
    output logic [mulWidth-1:0]            mulA,
    output logic [mulWidth-1:0]            mulB,
    input  logic                           mulDone,
    input  logic [2*mulWidth-1:0]          mulProduct,
    output logic                           retireValid,
    output logic [isaPkg::regIdxWidth-1:0] retireReg,
    output logic [31:0]                    retireData
);

    localparam int numRegs = 2 ** isaPkg::regIdxWidth;

    logic [31:0]                    regFile [numRegs];
    logic [isaPkg::regIdxWidth-1:0] mulRd;
    isaPkg::opcode_e                opcode;
    logic [31:0]                    aluSrc1;
    logic [31:0]                    aluSrc2;
    logic [31:0]                    brSrc1;
    logic [31:0]                    brSrc2;
    logic [31:0]                    immExt;
    logic                           isAdd;
    logic                           isAddi;
    logic                           isBeq;
    logic                           isBr;

    // ==============================
    // Decode and operand read
    // ==============================
    assign opcode = filteredInstruction.aluView.opcode;

    assign isAdd    = issueValid && (opcode == isaPkg::ADD);
    assign isAddi   = issueValid && (opcode == isaPkg::ADDI);
    assign isBeq    = issueValid && (opcode == isaPkg::BEQ);
    assign isBr     = issueValid && (opcode == isaPkg::BR);
    assign mulStart = issueValid && (opcode == isaPkg::MUL);

    // ALU format sources
    assign aluSrc1 = regFile[filteredInstruction.aluView.rs1];
    assign aluSrc2 = regFile[filteredInstruction.aluView.rs2];
    assign immExt  = {{16{filteredInstruction.aluView.imm16[15]}},
                      filteredInstruction.aluView.imm16};

    // Branch format sources
    assign brSrc1 = regFile[filteredInstruction.brView.rs1];
    assign brSrc2 = regFile[filteredInstruction.brView.rs2];

    // ==============================
    // Branch resolution
    // ==============================
    assign redirect.exeOverride   = isBeq && (brSrc1 == brSrc2);
    assign redirect.exeData       = filteredInstruction.brView.imm16;
    assign redirect.exeOverrideBR = isBr;
    assign redirect.readDataFirst = brSrc1;

    // ==============================
    // Multiplier launch
    // ==============================
    assign mulA = aluSrc1[mulWidth-1:0];
    assign mulB = aluSrc2[mulWidth-1:0];

    // Destination for the product, written when done arrives
    always_ff @(posedge clk) begin
        if (mulStart) begin
            mulRd <= filteredInstruction.aluView.rd;
        end
    end

    // ==============================
    // Retire and writeback
    // ==============================
    always_comb begin
        retireValid = 1'b0;
        retireReg   = filteredInstruction.aluView.rd;
        retireData  = aluSrc1 + aluSrc2;

        // Product only lands during the hold, never alongside an issue
        if (mulDone) begin
            retireValid = 1'b1;
            retireReg   = mulRd;
            retireData  = 32'(mulProduct);
        end else if (isAdd) begin
            retireValid = 1'b1;
        end else if (isAddi) begin
            retireValid = 1'b1;
            retireData  = aluSrc1 + immExt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regFile[i] <= '0;
            end
        end else if (retireValid) begin
            regFile[retireReg] <= retireData;
        end
    end

endmodule

//--- iFetch.sv
// ==============================
// Fetch unit with PC register, next-PC priority select
// and the idle/filter/microcode-hold FSM
// ==============================
`timescale 1ns/10ps

module iFetch (
    input  logic               clk,
    input  logic               rst,
    input  isaPkg::instrWord_u fetchedInstruction,
    redirectIf.fetch           redirect,
    input  logic               control,
    output logic [31:0]        programCounter,
    output isaPkg::instrWord_u filteredInstruction,
    output logic               issueValid
);

    fetchPkg::fetchState_e state;
    fetchPkg::fetchState_e stateNext;
    logic [31:0]           pcNext;
    isaPkg::instrWord_u    heldInstruction;
    isaPkg::opcode_e       fetchedOpcode;
    logic [31:0]           exeOffset;
    logic [31:0]           regOffset;
    logic [31:0]           branchOffset;

    // ==============================
    // Offsets
    // ==============================
    assign fetchedOpcode = fetchedInstruction.brView.opcode;

    // All three targets are PC relative, sign extended to 32 bits
    assign exeOffset    = {{16{redirect.exeData[15]}}, redirect.exeData};
    assign regOffset    = {{16{redirect.readDataFirst[15]}}, redirect.readDataFirst[15:0]};
    assign branchOffset = {{16{fetchedInstruction.brView.imm16[15]}},
                           fetchedInstruction.brView.imm16};

    // ==============================
    // State and PC registers
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= fetchPkg::sIdle;
            programCounter <= fetchPkg::resetPc;
        end else begin
            state          <= stateNext;
            programCounter <= pcNext;
        end
    end

    // Capture the MUL word on entry to the hold
    always_ff @(posedge clk) begin
        if (state == fetchPkg::sFilter && stateNext == fetchPkg::sUcode) begin
            heldInstruction <= fetchedInstruction;
        end
    end

    // ==============================
    // Next state and next PC
    // ==============================
    always_comb begin
        stateNext = state;
        pcNext    = programCounter;

        case (state)
            fetchPkg::sIdle: begin
                stateNext = fetchPkg::sFilter;
            end

            fetchPkg::sFilter: begin
                // Execute redirects win over the local decode
                if (redirect.exeOverride) begin
                    pcNext = programCounter + exeOffset;
                end else if (redirect.exeOverrideBR) begin
                    pcNext = programCounter + regOffset;
                end else if (fetchedOpcode == isaPkg::B) begin
                    pcNext = programCounter + branchOffset;
                end else if (fetchedOpcode == isaPkg::NOP) begin
                    pcNext = programCounter + fetchPkg::pcStep;
                end else if (control) begin
                    // Multiplier running, freeze PC
                    stateNext = fetchPkg::sUcode;
                end else begin
                    pcNext = programCounter + fetchPkg::pcStep;
                end
            end

            fetchPkg::sUcode: begin
                // Step past the MUL once the multiplier lets go
                if (!control) begin
                    stateNext = fetchPkg::sFilter;
                    pcNext    = programCounter + fetchPkg::pcStep;
                end
            end

            default: begin
                stateNext = fetchPkg::sIdle;
            end
        endcase
    end

    // ==============================
    // Issue to execute
    // ==============================
    assign issueValid          = (state == fetchPkg::sFilter);
    assign filteredInstruction = (state == fetchPkg::sUcode) ? heldInstruction
                                                             : fetchedInstruction;

endmodule

//--- instrRom.sv
// ==============================
// Word-addressed program ROM, combinational read
// ==============================
`timescale 1ns/10ps

module instrRom #(
    parameter int romDepth = 64
) (
    input  logic [31:0]        programCounter,
    output isaPkg::instrWord_u fetchedInstruction
);

    localparam int addrWidth = $clog2(romDepth);

    isaPkg::instrWord_u romArray [romDepth];
    logic [29:0]        wordIndex;
    logic               inRange;

    // Program image
    initial begin
        $readmemh("program.hex", romArray);
    end

    // Byte PC to word index
    assign wordIndex = programCounter[31:2];
    assign inRange   = (wordIndex < 30'(romDepth));

    // Past the end of the image reads as all zeros
    assign fetchedInstruction = inRange ? romArray[wordIndex[addrWidth-1:0]] : '0;

endmodule

//--- redirectIf.sv
// ==============================
// Branch redirect interface from execute to fetch
// ==============================
`timescale 1ns/10ps

interface redirectIf;

    // BEQ taken, with its 16-bit offset
    logic        exeOverride;
    logic [15:0] exeData;
    // BR, target offset comes from rs1
    logic        exeOverrideBR;
    logic [31:0] readDataFirst;

    modport exec (
        output exeOverride,
        output exeData,
        output exeOverrideBR,
        output readDataFirst
    );

    modport fetch (
        input exeOverride,
        input exeData,
        input exeOverrideBR,
        input readDataFirst
    );

endinterface

//--- fetchPkg.sv
// ==============================
// Fetch package with FSM states, reset PC and PC step
// ==============================
package fetchPkg;

    // Fetch FSM
    // sIdle only lasts the first cycle out of reset
    typedef enum logic [1:0] {
        sIdle,
        sFilter,
        sUcode
    } fetchState_e;

    // Program starts at word zero
    localparam logic [31:0] resetPc = 32'h0000_0000;

    // Byte step between sequential instructions
    localparam logic [31:0] pcStep = 32'd4;

endpackage

//--- isaPkg.sv
// ==============================
// Instruction-set package with opcodes, register index width
// and the instruction word with its ALU and branch decodings
// ==============================
package isaPkg;

    // Eight architectural registers
    localparam int regIdxWidth = 3;

    // ==============================
    // Opcodes, instruction bits [31:25]
    // ==============================
    typedef enum logic [6:0] {
        ADD  = 7'b0000001,
        ADDI = 7'b0000010,
        MUL  = 7'b0000100,
        BEQ  = 7'b1000001,
        BR   = 7'b1000010,
        B    = 7'b1100000,
        NOP  = 7'b1100100
    } opcode_e;

    // ==============================
    // Instruction word
    // ==============================
    // Same 32 bits, decoded two ways depending on the opcode class
    typedef union packed {
        // ADD, ADDI, MUL
        struct packed {
            opcode_e                opcode;
            logic [regIdxWidth-1:0] rd;
            logic [regIdxWidth-1:0] rs1;
            logic [regIdxWidth-1:0] rs2;
            logic [15:0]            imm16;
        } aluView;
        // BEQ, BR, B and NOP
        // Sources move up into the rd slot, low three bits unused
        struct packed {
            opcode_e                opcode;
            logic [regIdxWidth-1:0] rs1;
            logic [regIdxWidth-1:0] rs2;
            logic [2:0]             pad;
            logic [15:0]            imm16;
        } brView;
    } instrWord_u;

endpackage
